// File: logic/am9150_pkg.sv
// Widths, types and request formats shared by the Am9150 memory subsystem
// Word address top bit picks the bank, low bits go straight to every chip
package am9150_pkg;

    localparam int ADDR_W         = 11;             // 2048 words over two banks
    localparam int CHIP_ADDR_W    = 10;             // 1024 locations per chip
    localparam int DATA_W         = 16;
    localparam int NIBBLE_W       = 4;              // One chip supplies one nibble
    localparam int CHIPS_PER_BANK = DATA_W / NIBBLE_W;
    localparam int NUM_BANKS      = 2;
    localparam int CREDITS        = 4;              // Host credits and queue depth
    localparam int CREDIT_CNT_W   = 3;              // Holds 0 to CREDITS

    typedef logic [ADDR_W-1:0]      word_addr_t;
    typedef logic [CHIP_ADDR_W-1:0] chip_addr_t;
    typedef logic [DATA_W-1:0]      data_word_t;
    typedef logic [NIBBLE_W-1:0]    nibble_t;

    // Host operations
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_CLEAR = 2'd2                             // Zeros the whole array
    } mem_op_t;

    // Request word, 29 bits
    typedef struct packed {
        mem_op_t    op;
        word_addr_t addr;                           // Unused by a clear
        data_word_t data;                           // Write data only
    } mem_req_t;

    // Read response, 27 bits
    typedef struct packed {
        word_addr_t addr;                           // Echo of the request address
        data_word_t data;
    } mem_rsp_t;

    // Chip access sequence
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,                            // Waiting for a queued request
        S_SETUP  = 2'd1,                            // Address and select
        S_STROBE = 2'd2                             // Write, read or reset pin active
    } seq_state_t;

endpackage

// File: logic/am9150.sv
// Cycle-based model of one Am9150 1024 x 4 SRAM, no access timing
// Write and reset act at the clock edge, outputs read as zero when not driving
module am9150 (
    input  logic                   CLOCK,
    input  am9150_pkg::chip_addr_t address,
    input  am9150_pkg::nibble_t    data_in,
    output am9150_pkg::nibble_t    data_out,
    input  logic                   write_enable_n,   // /W
    input  logic                   chip_select_n,    // /S
    input  logic                   output_enable_n,  // /G
    input  logic                   clear_n           // /R, reset of whole array
);

    am9150_pkg::nibble_t mem [2**am9150_pkg::CHIP_ADDR_W];
    logic                reading;

    // Reset wins over write when both pins are low
    always_ff @(posedge CLOCK) begin
        if (!chip_select_n) begin
            if (!clear_n) begin
                for (int i = 0; i < 2**am9150_pkg::CHIP_ADDR_W; i++) begin
                    mem[i] <= '0;                   // Every location to low
                end
            end else if (!write_enable_n) begin
                mem[address] <= data_in;
            end
        end
    end

    // Read path follows the address combinationally
    assign reading = !chip_select_n && !output_enable_n && write_enable_n && clear_n;

    // Zero instead of high impedance so the array can OR the outputs
    assign data_out = reading ? mem[address] : '0;

    // Write and reset never requested together on a selected chip
    assert property (@(posedge CLOCK)
        (!write_enable_n && !clear_n) |-> chip_select_n)
        else $error("am9150: write and reset low together while selected");

endmodule

// File: logic/sram_array.sv
// Two banks of four Am9150 chips forming a 2048 x 16 word store
// A clear selects both banks, reads OR all chip outputs like a wired bus
module sram_array (
    input  logic                   CLOCK,
    input  am9150_pkg::chip_addr_t chip_addr,
    input  logic                   bank_sel,         // Top word address bit
    input  am9150_pkg::data_word_t wdata,
    input  logic                   select_n,
    input  logic                   write_n,
    input  logic                   read_n,
    input  logic                   clear_n,
    output am9150_pkg::data_word_t rdata
);

    // Per-bank chip select, active low
    logic [am9150_pkg::NUM_BANKS-1:0] bank_cs_n;

    // Raw nibble from every chip, zero unless that chip is reading
    am9150_pkg::nibble_t chip_q [am9150_pkg::NUM_BANKS][am9150_pkg::CHIPS_PER_BANK];

    for (genvar b = 0; b < am9150_pkg::NUM_BANKS; b++) begin : g_bank

        // Addressed bank only, except during a clear
        assign bank_cs_n[b] = select_n || (clear_n && (int'(bank_sel) != b));

        for (genvar c = 0; c < am9150_pkg::CHIPS_PER_BANK; c++) begin : g_chip
            // Chip c holds nibble c of the word
            am9150 chip_inst (
                .CLOCK           (CLOCK),
                .address         (chip_addr),
                .data_in         (wdata[c*am9150_pkg::NIBBLE_W +: am9150_pkg::NIBBLE_W]),
                .data_out        (chip_q[b][c]),
                .write_enable_n  (write_n),
                .chip_select_n   (bank_cs_n[b]),
                .output_enable_n (read_n),         // Shared /G line
                .clear_n         (clear_n)
            );
        end

    end

    // Wired-OR of both banks per nibble lane
    always_comb begin
        rdata = '0;
        for (int b = 0; b < am9150_pkg::NUM_BANKS; b++) begin
            for (int c = 0; c < am9150_pkg::CHIPS_PER_BANK; c++) begin
                rdata[c*am9150_pkg::NIBBLE_W +: am9150_pkg::NIBBLE_W] |= chip_q[b][c];
            end
        end
    end

endmodule

// File: logic/cmd_queue.sv
// Request FIFO with one entry per host credit, depth must be a power of two
// Host never pushes into a full queue, a credit goes back with each pop
module cmd_queue (
    input  logic                 CLOCK,
    input  logic                 RESET_n,
    input  am9150_pkg::mem_req_t req,
    input  logic                 req_valid,
    output am9150_pkg::mem_req_t head,
    output logic                 head_valid,
    input  logic                 pop,
    output logic                 credit_return
);

    typedef logic [$clog2(am9150_pkg::CREDITS)-1:0] ptr_t;

    am9150_pkg::mem_req_t                fifo_mem [am9150_pkg::CREDITS];
    ptr_t                                wr_ptr;
    ptr_t                                rd_ptr;
    logic [am9150_pkg::CREDIT_CNT_W-1:0] count;   // Entries held

    // Payload storage
    always_ff @(posedge CLOCK) begin
        if (req_valid) begin
            fifo_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge CLOCK) begin
        if (!RESET_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                      // Empty after reset
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;       // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                     // Push and pop together hold the count
            endcase
        end
    end

    assign head          = fifo_mem[rd_ptr];
    assign head_valid    = (count != '0);
    assign credit_return = pop;                // Same cycle as the retire

    // Credit accounting keeps the queue from overflowing
    assert property (@(posedge CLOCK) disable iff (!RESET_n)
        req_valid |-> (count != am9150_pkg::CREDIT_CNT_W'(am9150_pkg::CREDITS)))
        else $error("cmd_queue: push into a full queue");

    // Sequencer retires only what it was shown
    assert property (@(posedge CLOCK) disable iff (!RESET_n)
        pop |-> (count != '0))
        else $error("cmd_queue: pop from an empty queue");

endmodule

// File: logic/mem_sequencer.sv
// Turns one queued request into Am9150 pin activity, one op at a time
// Each op is one setup and one strobe cycle, with an idle cycle between ops
// Read data is sampled in the strobe cycle and leaves as the response
module mem_sequencer (
    input  logic                   CLOCK,
    input  logic                   RESET_n,
    input  am9150_pkg::mem_req_t   head,
    input  logic                   head_valid,
    output logic                   pop,
    output am9150_pkg::chip_addr_t chip_addr,
    output logic                   bank_sel,
    output am9150_pkg::data_word_t wdata,
    output logic                   select_n,
    output logic                   write_n,
    output logic                   read_n,
    output logic                   clear_n,
    input  am9150_pkg::data_word_t rdata,
    output am9150_pkg::mem_rsp_t   rsp,
    output logic                   rsp_valid
);

    am9150_pkg::seq_state_t state;
    am9150_pkg::seq_state_t state_nxt;
    am9150_pkg::mem_req_t   req_q;             // Op in flight
    logic                   take_head;
    logic                   in_access;         // Setup or strobe
    logic                   in_strobe;

    // A new op is taken only from idle
    assign take_head = (state == am9150_pkg::S_IDLE) && head_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            am9150_pkg::S_IDLE: begin
                if (head_valid) begin
                    state_nxt = am9150_pkg::S_SETUP;
                end
            end
            am9150_pkg::S_SETUP: begin
                state_nxt = am9150_pkg::S_STROBE;   // Address settles for one cycle
            end
            am9150_pkg::S_STROBE: begin
                state_nxt = am9150_pkg::S_IDLE;     // Head pops here, next one seen in idle
            end
            default: begin
                state_nxt = am9150_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLOCK) begin
        if (!RESET_n) begin
            state <= am9150_pkg::S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request copy holds the pins steady while the queue moves on
    always_ff @(posedge CLOCK) begin
        if (take_head) begin
            req_q <= head;
        end
    end

    assign in_access = (state == am9150_pkg::S_SETUP) || (state == am9150_pkg::S_STROBE);
    assign in_strobe = (state == am9150_pkg::S_STROBE);

    // Word address split into bank and chip address
    assign chip_addr = req_q.addr[am9150_pkg::CHIP_ADDR_W-1:0];
    assign bank_sel  = req_q.addr[am9150_pkg::ADDR_W-1];
    assign wdata     = req_q.data;

    // Chip pins, all high while idle
    assign select_n = !in_access;
    assign write_n  = !(in_strobe && (req_q.op == am9150_pkg::OP_WRITE));
    assign read_n   = !(in_strobe && (req_q.op == am9150_pkg::OP_READ));
    assign clear_n  = !(in_strobe && (req_q.op == am9150_pkg::OP_CLEAR)); // Array opens both banks

    // Retire every op at its strobe
    assign pop = in_strobe;

    // Response straight from the array read path
    assign rsp_valid = in_strobe && (req_q.op == am9150_pkg::OP_READ);
    assign rsp       = '{addr: req_q.addr, data: rdata};

    // Never more than one strobe
    assert property (@(posedge CLOCK) disable iff (!RESET_n)
        $onehot0({~write_n, ~read_n, ~clear_n}))
        else $error("mem_sequencer: more than one strobe low");

endmodule

// File: logic/am9150_mem_top.sv
// 2048 x 16 SRAM subsystem on Am9150 chips behind a credit-based request port
// Host starts with CREDITS credits and must always accept responses
module am9150_mem_top (
    input  logic                 CLOCK,
    input  logic                 RESET_n,
    input  am9150_pkg::mem_req_t req,
    input  logic                 req_valid,
    output logic                 credit_return,
    output am9150_pkg::mem_rsp_t rsp,
    output logic                 rsp_valid
);

    // Queue to sequencer
    am9150_pkg::mem_req_t   head;
    logic                   head_valid;
    logic                   pop;

    // Sequencer to array
    am9150_pkg::chip_addr_t chip_addr;
    logic                   bank_sel;
    am9150_pkg::data_word_t wdata;
    logic                   select_n;
    logic                   write_n;
    logic                   read_n;
    logic                   clear_n;
    am9150_pkg::data_word_t rdata;

    cmd_queue cmd_queue_inst (
        .CLOCK         (CLOCK),
        .RESET_n       (RESET_n),
        .req           (req),
        .req_valid     (req_valid),
        .head          (head),
        .head_valid    (head_valid),
        .pop           (pop),
        .credit_return (credit_return)
    );

    mem_sequencer mem_sequencer_inst (
        .CLOCK      (CLOCK),
        .RESET_n    (RESET_n),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .chip_addr  (chip_addr),
        .bank_sel   (bank_sel),
        .wdata      (wdata),
        .select_n   (select_n),
        .write_n    (write_n),
        .read_n     (read_n),
        .clear_n    (clear_n),
        .rdata      (rdata),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid)
    );

    sram_array sram_array_inst (
        .CLOCK     (CLOCK),
        .chip_addr (chip_addr),
        .bank_sel  (bank_sel),
        .wdata     (wdata),
        .select_n  (select_n),
        .write_n   (write_n),
        .read_n    (read_n),
        .clear_n   (clear_n),
        .rdata     (rdata)
    );

endmodule

// File: tests/am9150_mem_tb.sv
// Testbench for the Am9150 memory subsystem, host side with credit tracking
// Reads are only issued to words that a clear or a write has defined
// Outputs are sampled on the falling edge, inputs change 1 ns after the rising edge
module am9150_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 500;                // Per wait loop
    localparam int WORDS          = 2**am9150_pkg::ADDR_W;

    logic                 CLOCK;
    logic                 RESET_n;
    am9150_pkg::mem_req_t req;
    logic                 req_valid;
    logic                 credit_return;
    am9150_pkg::mem_rsp_t rsp;
    logic                 rsp_valid;

    // Shadow of the whole array
    am9150_pkg::data_word_t shadow [WORDS];
    logic                   known  [WORDS];             // Cleared or written since reset
    am9150_pkg::mem_rsp_t   exp_q [$];                  // Reads in flight, request order

    int credits;
    int credits_min;                                    // Lowest credit count seen
    int returns;                                        // credit_return pulses
    int issued;                                         // Requests sent
    int stall_cycles;                                   // Cycles the host held back
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int err_mark;
    int seed;

    am9150_mem_top am9150_mem_top_inst (
        .CLOCK         (CLOCK),
        .RESET_n       (RESET_n),
        .req           (req),
        .req_valid     (req_valid),
        .credit_return (credit_return),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid)
    );

    always #5 CLOCK = ~CLOCK;                           // 10 ns period

    // Expected read data from the shadow array
    function automatic am9150_pkg::data_word_t expected_read(input am9150_pkg::word_addr_t addr);
        if (!known[addr]) begin
            return 'x;                                  // Never asked for by the stimulus
        end
        return shadow[addr];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // Counts, verdict, end of simulation
    task automatic finish_run();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Sends one request once a credit is held, updates the shadow in request order
    task automatic issue(input am9150_pkg::mem_op_t op, input am9150_pkg::word_addr_t addr,
                         input am9150_pkg::data_word_t data);
        int                   waited;
        am9150_pkg::mem_rsp_t entry;
        waited = 0;
        while (credits == 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge CLOCK);
            #1;
            waited++;
            stall_cycles++;
        end
        if (credits == 0) begin
            errors++;
            $display("timeout: host waited %0d cycles and no credit came back", waited);
        end else begin
            case (op)
                am9150_pkg::OP_WRITE: begin
                    shadow[addr] = data;
                    known[addr]  = 1'b1;
                end
                am9150_pkg::OP_CLEAR: begin
                    for (int i = 0; i < WORDS; i++) begin
                        shadow[i] = '0;
                        known[i]  = 1'b1;
                    end
                end
                default: begin
                    entry.addr = addr;
                    entry.data = expected_read(addr);
                    exp_q.push_back(entry);
                end
            endcase
            req       = '{op: op, addr: addr, data: data};
            req_valid = 1'b1;
            credits--;
            issued++;
            if (credits < credits_min) begin
                credits_min = credits;
            end
            @(posedge CLOCK);
            #1;
            req_valid = 1'b0;                           // One cycle per request
        end
    endtask

    // Waits for every read answered and every credit back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || credits != am9150_pkg::CREDITS)
               && waited < TIMEOUT_CYCLES) begin
            @(posedge CLOCK);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || credits != am9150_pkg::CREDITS) begin
            errors++;
            $display("timeout: %0d reads unanswered and %0d credits held after %0d cycles",
                     exp_q.size(), credits, waited);
        end
    endtask

    // Credit accounting on the host side
    always @(negedge CLOCK) begin
        if (RESET_n && credit_return) begin
            credits++;
            returns++;
            if (credits > am9150_pkg::CREDITS) begin
                errors++;
                $display("credit returned at %0t ns while the host held every credit", $time);
            end
        end
    end

    // Response checker, compares against the oldest outstanding read
    always @(negedge CLOCK) begin
        am9150_pkg::mem_rsp_t exp;
        if (RESET_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at %0t ns with no read outstanding", $time);
            end else begin
                exp = exp_q.pop_front();
                check_value("rsp.addr", 32'(rsp.addr), 32'(exp.addr));  // Also shows order
                check_value("rsp.data", 32'(rsp.data), 32'(exp.data));
            end
        end
    end

    initial begin
        am9150_pkg::mem_op_t    op;
        am9150_pkg::word_addr_t addr;
        am9150_pkg::data_word_t data;
        logic [31:0]            rnd;
        CLOCK        = 1'b0;
        RESET_n      = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        seed         = 81;
        credits      = am9150_pkg::CREDITS;
        credits_min  = am9150_pkg::CREDITS;
        returns      = 0;
        issued       = 0;
        stall_cycles = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = '0;
            known[i]  = 1'b0;                           // Contents undefined after reset
        end
        repeat (16) @(posedge CLOCK);
        #1;
        RESET_n = 1'b1;

        // Clear, then the corners of both banks
        issue(am9150_pkg::OP_CLEAR, '0, '0);
        issue(am9150_pkg::OP_READ, 11'd0, '0);
        issue(am9150_pkg::OP_READ, 11'd1023, '0);
        issue(am9150_pkg::OP_READ, 11'd1024, '0);
        issue(am9150_pkg::OP_READ, 11'd2047, '0);
        wait_drain();
        end_test(1, "initial clear");

        // Same chip address in both banks
        issue(am9150_pkg::OP_WRITE, 11'd1023, 16'hA5C3);
        issue(am9150_pkg::OP_WRITE, 11'd1024, 16'h5A3C);
        issue(am9150_pkg::OP_READ, 11'd1023, '0);
        issue(am9150_pkg::OP_READ, 11'd1024, '0);
        issue(am9150_pkg::OP_READ, 11'd2047, '0);       // Bank 1 twin of 1023 stays zero
        issue(am9150_pkg::OP_READ, 11'd0, '0);          // Bank 0 twin of 1024 stays zero
        wait_drain();
        end_test(2, "bank boundary");

        // Many writes, a clear, then read them all back
        for (int i = 0; i < 48; i++) begin
            issue(am9150_pkg::OP_WRITE, am9150_pkg::word_addr_t'((i * 173 + 5) % WORDS),
                  am9150_pkg::data_word_t'(i * 16'h0911 + 1));
        end
        issue(am9150_pkg::OP_CLEAR, '0, '0);
        for (int i = 0; i < 48; i++) begin
            issue(am9150_pkg::OP_READ, am9150_pkg::word_addr_t'((i * 173 + 5) % WORDS), '0);
        end
        wait_drain();
        end_test(3, "second clear");

        // Back-to-back burst runs the host out of credits
        stall_cycles = 0;
        credits_min  = credits;
        for (int i = 0; i < 4; i++) begin
            issue(am9150_pkg::OP_WRITE, am9150_pkg::word_addr_t'(100 + i),
                  am9150_pkg::data_word_t'(16'h1234 * (i + 1)));
        end
        for (int i = 0; i < 4; i++) begin
            issue(am9150_pkg::OP_READ, am9150_pkg::word_addr_t'(100 + i), '0);
        end
        check_value("lowest credit count", 32'(credits_min), 32'd0);
        check_value("host stalled", 32'(stall_cycles > 0), 32'd1);
        wait_drain();
        check_value("credit_return pulses", 32'(returns), 32'(issued));
        end_test(4, "credit burst");

        // Random mix, about 10 percent clears
        for (int i = 0; i < 300; i++) begin
            rnd  = $random(seed);
            addr = am9150_pkg::word_addr_t'($random(seed));
            data = am9150_pkg::data_word_t'($random(seed));
            if (rnd % 32'd100 < 32'd10) begin
                op = am9150_pkg::OP_CLEAR;
            end else if (rnd % 32'd100 < 32'd55 || !known[addr]) begin
                op = am9150_pkg::OP_WRITE;              // Undefined words get written first
            end else begin
                op = am9150_pkg::OP_READ;
            end
            issue(op, addr, data);
        end
        wait_drain();
        check_value("credit_return pulses", 32'(returns), 32'(issued));
        end_test(5, "random operations");

        finish_run();
    end

endmodule

// File: am9150_mem.f
logic/am9150_pkg.sv
logic/am9150.sv
logic/sram_array.sv
logic/cmd_queue.sv
logic/mem_sequencer.sv
logic/am9150_mem_top.sv
tests/am9150_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f am9150_mem.f \
    --top-module am9150_mem_tb --Mdir obj_dir -o am9150_mem_sim > build.log 2>&1 ||
    { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/am9150_mem_sim > sim.log 2>&1 ||
    { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log &&
    { echo "Simulation failed"; exit 1; } ||
    { echo "Simulation passed"; exit 0; }
